// ==== source/readout_pkg.sv ====
`default_nettype none

package readout_pkg;

    // ========================================
    // Sizes and defaults
    // ========================================
    localparam int WORD_BITS = 16;

    localparam int DEF_IMG_WIDTH    = 16;
    localparam int DEF_IMG_HEIGHT   = 16;
    localparam int DEF_HEADER_WORDS = 4;
    localparam int DEF_PAD_WORDS    = 2;
    localparam int DEF_FIFO_DEPTH   = 4;

    // Thumbnail keeps a THUMB_KEEP square out of every THUMB_TILE square
    localparam int THUMB_TILE = 8;
    localparam int THUMB_KEEP = 2;

    // ========================================
    // Types
    // ========================================
    // One output word, last marks the end of a frame
    typedef struct packed {
        logic [WORD_BITS-1:0] data;
        logic                 last;
    } word_t;

    // One accepted pixel as seen by the framer
    typedef struct packed {
        logic [WORD_BITS-1:0] data;
        logic                 keep;
        logic                 last;
    } pixel_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        PIXELS,
        CHECKSUM,
        PADDING
    } phase_t;

endpackage

`default_nettype wire

// ==== source/pixel_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_filter #(
    parameter int IMG_WIDTH  = readout_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = readout_pkg::DEF_IMG_HEIGHT
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear,
    input  logic                               thumb,
    input  logic                               enable,
    input  logic                               pix_valid,
    input  logic [readout_pkg::WORD_BITS-1:0]  pix_data,
    output logic                               pix_ready,
    output readout_pkg::pixel_t                pixel,
    output logic                               pixel_fire
);
    localparam int PIX_COUNT = IMG_WIDTH * IMG_HEIGHT;
    localparam int X_BITS    = $clog2(IMG_WIDTH + 1);
    localparam int Y_BITS    = $clog2(IMG_HEIGHT + 1);
    localparam int N_BITS    = $clog2(PIX_COUNT + 1);
    localparam logic [X_BITS-1:0] X_LAST = X_BITS'(IMG_WIDTH - 1);
    localparam logic [N_BITS-1:0] N_LAST = N_BITS'(PIX_COUNT - 1);

    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
    logic [N_BITS-1:0] taken;
    logic              done;
    logic              x_in_corner;
    logic              y_in_corner;

    assign x_in_corner = (x % readout_pkg::THUMB_TILE) < readout_pkg::THUMB_KEEP;
    assign y_in_corner = (y % readout_pkg::THUMB_TILE) < readout_pkg::THUMB_KEEP;

    // Stop accepting once the final pixel of the image went through
    assign pix_ready  = enable && !done;
    assign pixel_fire = pix_valid && pix_ready;

    assign pixel.data = pix_data;
    assign pixel.keep = !thumb || (x_in_corner && y_in_corner);
    assign pixel.last = (taken == N_LAST);

    // Raster position of the next pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x     <= '0;
            y     <= '0;
            taken <= '0;
            done  <= 1'b0;
        end else if (clear) begin
            x     <= '0;
            y     <= '0;
            taken <= '0;
            done  <= 1'b0;
        end else if (pixel_fire) begin
            taken <= taken + 1'b1;
            if (x == X_LAST) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
            if (pixel.last) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fletcher_checksum.sv ====
`timescale 1ns/1ps
`default_nettype none

module fletcher_checksum (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear,
    input  logic                               en,
    input  logic [readout_pkg::WORD_BITS-1:0]  din,
    output logic [readout_pkg::WORD_BITS-1:0]  sum_a,
    output logic [readout_pkg::WORD_BITS-1:0]  sum_b
);
    localparam int W = readout_pkg::WORD_BITS;
    localparam logic [W:0] MODULUS = (W + 1)'(65535);

    logic [W-1:0] a_next;

    // Addition modulo 65535, both operands at most 65535
    function automatic logic [W-1:0] add_mod(input logic [W-1:0] lhs, input logic [W-1:0] rhs);
        logic [W:0] total;
        total = {1'b0, lhs} + {1'b0, rhs};
        if (total >= MODULUS) begin
            total = total - MODULUS;
        end
        return total[W-1:0];
    endfunction

    assign a_next = add_mod(sum_a, din);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= a_next;
            sum_b <= add_mod(sum_b, a_next);
        end
    end

endmodule

`default_nettype wire

// ==== source/readout_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module readout_framer #(
    parameter int HEADER_WORDS = readout_pkg::DEF_HEADER_WORDS,
    parameter int PAD_WORDS    = readout_pkg::DEF_PAD_WORDS,
    parameter int FIFO_DEPTH   = readout_pkg::DEF_FIFO_DEPTH
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            start,
    input  logic [HEADER_WORDS*readout_pkg::WORD_BITS-1:0]  header,
    input  logic                                            thumb,
    output logic                                            busy,
    output logic                                            filter_clear,
    output logic                                            filter_thumb,
    output logic                                            filter_enable,
    input  readout_pkg::pixel_t                             pixel,
    input  logic                                            pixel_fire,
    output logic                                            push,
    output readout_pkg::word_t                              push_word,
    input  logic                                            credit_return
);
    localparam int W         = readout_pkg::WORD_BITS;
    localparam int HDR_BITS  = HEADER_WORDS * W;
    localparam int CNT_MAX   = (HEADER_WORDS > PAD_WORDS) ? HEADER_WORDS : PAD_WORDS;
    localparam int CNT_BITS  = $clog2(CNT_MAX + 3);
    localparam int CRED_BITS = $clog2(FIFO_DEPTH + 1);
    localparam logic [CNT_BITS-1:0] HDR_LAST = CNT_BITS'(HEADER_WORDS - 1);
    localparam logic [CNT_BITS-1:0] PAD_LAST = CNT_BITS'(PAD_WORDS - 1);

    readout_pkg::phase_t  phase;
    logic [CNT_BITS-1:0]  word_cnt;
    logic [CRED_BITS-1:0] credits;
    logic [HDR_BITS-1:0]  hdr_shift;
    logic                 settle;
    logic                 has_credit;
    logic                 accept;
    logic                 sum_en;
    logic [W-1:0]         sum_a;
    logic [W-1:0]         sum_b;

    assign has_credit    = (credits != '0);
    assign busy          = (phase != readout_pkg::IDLE);
    assign accept        = start && !busy;
    assign filter_clear  = accept;
    assign filter_enable = (phase == readout_pkg::PIXELS) && has_credit;

    // Only header and pixel words count toward the checksum
    assign sum_en = push && (phase == readout_pkg::HEADER || phase == readout_pkg::PIXELS);

    fletcher_checksum checksum_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (accept),
        .en    (sum_en),
        .din   (push_word.data),
        .sum_a (sum_a),
        .sum_b (sum_b)
    );

    // ========================================
    // Word selection
    // ========================================
    always_comb begin
        push      = 1'b0;
        push_word = '0;
        case (phase)
            readout_pkg::HEADER: begin
                push           = has_credit;
                push_word.data = hdr_shift[HDR_BITS-1 -: W];
            end
            readout_pkg::PIXELS: begin
                // Dropped thumbnail pixels are consumed without a push
                push           = pixel_fire && pixel.keep;
                push_word.data = pixel.data;
            end
            readout_pkg::CHECKSUM: begin
                push           = has_credit && !settle;
                push_word.data = (word_cnt == '0) ? sum_b : sum_a;
                push_word.last = (PAD_WORDS == 0) && (word_cnt != '0);
            end
            readout_pkg::PADDING: begin
                push           = has_credit;
                push_word.last = (word_cnt == PAD_LAST);
            end
            default: begin
                push = 1'b0;
            end
        endcase
    end

    // ========================================
    // Phase sequencing and credits
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= readout_pkg::IDLE;
            word_cnt     <= '0;
            settle       <= 1'b0;
            filter_thumb <= 1'b0;
            credits      <= CRED_BITS'(FIFO_DEPTH);
        end else begin
            credits <= credits - CRED_BITS'(push) + CRED_BITS'(credit_return);
            case (phase)
                readout_pkg::IDLE: begin
                    if (accept) begin
                        phase        <= readout_pkg::HEADER;
                        word_cnt     <= '0;
                        filter_thumb <= thumb;
                    end
                end
                readout_pkg::HEADER: begin
                    if (push) begin
                        word_cnt <= (word_cnt == HDR_LAST) ? '0 : word_cnt + 1'b1;
                        if (word_cnt == HDR_LAST) begin
                            phase <= readout_pkg::PIXELS;
                        end
                    end
                end
                readout_pkg::PIXELS: begin
                    // One idle cycle lets the last pixel reach the sums
                    if (pixel_fire && pixel.last) begin
                        phase  <= readout_pkg::CHECKSUM;
                        settle <= 1'b1;
                    end
                end
                readout_pkg::CHECKSUM: begin
                    settle <= 1'b0;
                    if (push) begin
                        word_cnt <= (word_cnt == '0) ? CNT_BITS'(1) : '0;
                        if (word_cnt != '0) begin
                            phase <= (PAD_WORDS == 0) ? readout_pkg::IDLE : readout_pkg::PADDING;
                        end
                    end
                end
                readout_pkg::PADDING: begin
                    if (push) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == PAD_LAST) begin
                            phase <= readout_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    phase <= readout_pkg::IDLE;
                end
            endcase
        end
    end

    // Header goes out most significant word first
    always_ff @(posedge clk) begin
        if (accept) begin
            hdr_shift <= header;
        end else if (phase == readout_pkg::HEADER && push) begin
            hdr_shift <= hdr_shift << W;
        end
    end

endmodule

`default_nettype wire

// ==== source/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH = readout_pkg::DEF_FIFO_DEPTH,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,
    output logic not_empty,
    output logic credit_return
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_pop;

    assign not_empty     = (count != '0);
    assign head          = mem[rd_ptr];
    assign do_pop        = pop && not_empty;
    // Each slot freed goes straight back to the producer
    assign credit_return = do_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/readout_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module readout_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               not_empty,
    input  readout_pkg::word_t head,
    output logic               pop,
    output logic               out_valid,
    input  logic               out_ready,
    output readout_pkg::word_t out_word
);
    logic load;

    // Register is free when empty or when the host takes it this cycle
    assign load = !out_valid || out_ready;
    assign pop  = load && not_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Word held until transferred
    always_ff @(posedge clk) begin
        if (pop) begin
            out_word <= head;
        end
    end

endmodule

`default_nettype wire

// ==== source/img_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module img_readout #(
    parameter int IMG_WIDTH    = readout_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT   = readout_pkg::DEF_IMG_HEIGHT,
    parameter int HEADER_WORDS = readout_pkg::DEF_HEADER_WORDS,
    parameter int PAD_WORDS    = readout_pkg::DEF_PAD_WORDS,
    parameter int FIFO_DEPTH   = readout_pkg::DEF_FIFO_DEPTH
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            start,
    input  logic [HEADER_WORDS*readout_pkg::WORD_BITS-1:0]  header,
    input  logic                                            thumb,
    output logic                                            busy,
    input  logic                                            pix_valid,
    input  logic [readout_pkg::WORD_BITS-1:0]               pix_data,
    output logic                                            pix_ready,
    output logic                                            out_valid,
    input  logic                                            out_ready,
    output readout_pkg::word_t                              out_word
);
    logic                filter_clear;
    logic                filter_thumb;
    logic                filter_enable;
    readout_pkg::pixel_t pixel;
    logic                pixel_fire;
    logic                push;
    readout_pkg::word_t  push_word;
    logic                credit_return;
    readout_pkg::word_t  head;
    logic                not_empty;
    logic                pop;

    // ========================================
    // Pixel side
    // ========================================
    pixel_filter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) pixel_filter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (filter_clear),
        .thumb      (filter_thumb),
        .enable     (filter_enable),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_ready  (pix_ready),
        .pixel      (pixel),
        .pixel_fire (pixel_fire)
    );

    readout_framer #(
        .HEADER_WORDS (HEADER_WORDS),
        .PAD_WORDS    (PAD_WORDS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) readout_framer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .header        (header),
        .thumb         (thumb),
        .busy          (busy),
        .filter_clear  (filter_clear),
        .filter_thumb  (filter_thumb),
        .filter_enable (filter_enable),
        .pixel         (pixel),
        .pixel_fire    (pixel_fire),
        .push          (push),
        .push_word     (push_word),
        .credit_return (credit_return)
    );

    // ========================================
    // Host side
    // ========================================
    credit_fifo #(
        .DEPTH (FIFO_DEPTH),
        .T     (readout_pkg::word_t)
    ) credit_fifo_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_data     (push_word),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    readout_port readout_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release reset just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/img_readout_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module img_readout_sva #(
    parameter int DEPTH = readout_pkg::DEF_FIFO_DEPTH
) (
    input logic               clk,
    input logic               rst_n,
    input logic               push,
    input logic               credit_return,
    input logic               out_valid,
    input logic               out_ready,
    input readout_pkg::word_t out_word
);
    // Words between framer and port, tracked from push and pop
    logic [7:0] level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            level <= level + 8'(push) - 8'(credit_return);
        end
    end

    fifo_within_depth: assert property (@(posedge clk) disable iff (!rst_n)
        level <= 8'(DEPTH))
        else $error("FIFO holds more than %0d words", DEPTH);

    // A push into a full FIFO needs a pop in the same cycle
    push_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !credit_return) |-> (level < 8'(DEPTH)))
        else $error("Word pushed into a full FIFO");

    out_word_held: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word)))
        else $error("out_word changed while the host held off out_ready");

endmodule

`default_nettype wire

// ==== testbench/img_readout_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module img_readout_tb;
    localparam int W            = readout_pkg::WORD_BITS;
    localparam int IMG_WIDTH    = readout_pkg::DEF_IMG_WIDTH;
    localparam int IMG_HEIGHT   = readout_pkg::DEF_IMG_HEIGHT;
    localparam int HEADER_WORDS = readout_pkg::DEF_HEADER_WORDS;
    localparam int PAD_WORDS    = readout_pkg::DEF_PAD_WORDS;
    localparam int FIFO_DEPTH   = readout_pkg::DEF_FIFO_DEPTH;
    localparam int HDR_BITS     = HEADER_WORDS * W;
    localparam int PIX_COUNT    = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_ROWS     = 5;
    localparam int QUIET_CYCLES = 6;
    localparam int BUSY_START   = 12;
    localparam logic [15:0] SEED = 16'd3673;

    typedef struct packed {
        logic                thumb;
        logic [HDR_BITS-1:0] header;
        logic [W-1:0]        base;
        logic                backpressure;
    } row_t;

    // thumb, header, first pixel value, random back-pressure
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b0, 64'h1234_5678_9ABC_DEF0, 16'h0100, 1'b0},
        '{1'b1, 64'hCAFE_0001_0002_0003, 16'h8000, 1'b0},
        '{1'b0, 64'h1234_5678_9ABC_DEF0, 16'h0100, 1'b1},
        '{1'b1, 64'hCAFE_0001_0002_0003, 16'h8000, 1'b1},
        '{1'b0, 64'hFFFF_0000_FFFF_8001, 16'hFF80, 1'b1}
    };

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [HDR_BITS-1:0] header;
    logic               thumb;
    logic               busy;
    logic               pix_valid;
    logic [W-1:0]       pix_data;
    logic               pix_ready;
    logic               out_valid;
    logic               out_ready;
    readout_pkg::word_t out_word;

    readout_pkg::word_t expected [$];
    logic [15:0]        lfsr_state;

    tb_clock clock_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    img_readout #(
        .IMG_WIDTH    (IMG_WIDTH),
        .IMG_HEIGHT   (IMG_HEIGHT),
        .HEADER_WORDS (HEADER_WORDS),
        .PAD_WORDS    (PAD_WORDS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) img_readout_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .header    (header),
        .thumb     (thumb),
        .busy      (busy),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    bind img_readout img_readout_sva #(.DEPTH(FIFO_DEPTH)) img_readout_sva_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_word      (out_word)
    );

    // ========================================
    // Helpers and reference model
    // ========================================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_random_bit(output logic value);
        value      = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    function automatic logic pixel_kept(input logic thumb_mode, input int index);
        int x;
        int y;
        x = index % IMG_WIDTH;
        y = index / IMG_WIDTH;
        return !thumb_mode || ((x % readout_pkg::THUMB_TILE) < readout_pkg::THUMB_KEEP
                               && (y % readout_pkg::THUMB_TILE) < readout_pkg::THUMB_KEEP);
    endfunction

    function automatic int word_count(input logic thumb_mode);
        int kept;
        kept = 0;
        for (int i = 0; i < PIX_COUNT; i++) begin
            if (pixel_kept(thumb_mode, i)) begin
                kept++;
            end
        end
        return HEADER_WORDS + kept + 2 + PAD_WORDS;
    endfunction

    task automatic append_word(input logic [W-1:0] data, input int total);
        readout_pkg::word_t entry;
        entry.data = data;
        entry.last = (expected.size() == total - 1);
        expected.push_back(entry);
    endtask

    // Header and kept pixels feed Fletcher-32 ahead of b, a and padding
    task automatic build_expected(input row_t row);
        int           total;
        int           sum_a;
        int           sum_b;
        logic [W-1:0] w;
        total = word_count(row.thumb);
        expected.delete();
        sum_a = 0;
        sum_b = 0;
        for (int k = 0; k < HEADER_WORDS + PIX_COUNT; k++) begin
            if (k < HEADER_WORDS) begin
                w = row.header[HDR_BITS-1-k*W -: W];
            end else if (pixel_kept(row.thumb, k - HEADER_WORDS)) begin
                w = row.base + W'(k - HEADER_WORDS);
            end else begin
                continue;
            end
            sum_a = (sum_a + int'(w)) % 65535;
            sum_b = (sum_b + sum_a) % 65535;
            append_word(w, total);
        end
        append_word(W'(sum_b), total);
        append_word(W'(sum_a), total);
        for (int p = 0; p < PAD_WORDS; p++) begin
            append_word('0, total);
        end
    endtask

    task automatic drive_handshake(input logic backpressure);
        logic ready_bit;
        logic valid_bit;
        if (backpressure) begin
            take_random_bit(ready_bit);
            take_random_bit(valid_bit);
            out_ready = ready_bit;
            pix_valid = valid_bit;
        end else begin
            out_ready = 1'b1;
            pix_valid = 1'b1;
        end
    endtask

    // ========================================
    // One frame per table row
    // ========================================
    task automatic run_frame(input row_t row);
        int                 pix_idx;
        int                 received;
        int                 cycle;
        logic               pix_fire;
        logic               frame_done;
        readout_pkg::word_t want;
        build_expected(row);
        pix_idx    = 0;
        received   = 0;
        cycle      = 0;
        frame_done = 1'b0;
        start      = 1'b1;
        header     = row.header;
        thumb      = row.thumb;
        pix_data   = row.base;
        drive_handshake(row.backpressure);
        while (!frame_done) begin
            @(negedge clk);
            pix_fire = pix_valid && pix_ready;
            if (out_valid && out_ready) begin
                want = expected.pop_front();
                assert (out_word === want)
                    else stop_on_error($sformatf(
                        "Mismatch at %0t ns: word %0d is %h last %b, expected %h last %b",
                        $time, received, out_word.data, out_word.last, want.data, want.last));
                received++;
                frame_done = (expected.size() == 0);
                if (frame_done) begin
                    assert (!busy) else stop_on_error("busy stayed high after the final word");
                end
            end
            @(posedge clk);
            #1;
            start = 1'b0;
            cycle++;
            // A second start in mid-frame must be ignored
            if (cycle == BUSY_START) begin
                assert (busy) else stop_on_error("busy was low in the middle of a frame");
                start  = 1'b1;
                header = ~row.header;
                thumb  = !row.thumb;
            end
            if (pix_fire) begin
                pix_idx++;
            end
            pix_data = row.base + W'(pix_idx);
            drive_handshake(row.backpressure);
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!out_valid && !busy)
                else stop_on_error("Another frame followed the completed one");
        end
        @(posedge clk);
        #1;
    endtask

    // ========================================
    // Main sequence and timeout
    // ========================================
    initial begin
        start      = 1'b0;
        header     = '0;
        thumb      = 1'b0;
        pix_valid  = 1'b0;
        pix_data   = '0;
        out_ready  = 1'b0;
        lfsr_state = SEED;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        assert (!busy && !pix_ready && !out_valid)
            else stop_on_error("Outputs were not idle after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_frame(ROWS[r]);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        int limit;
        int cycles;
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += 8 * word_count(ROWS[r].thumb);
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "Run timed out");
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/readout_pkg.sv
source/pixel_filter.sv
source/fletcher_checksum.sv
source/readout_framer.sv
source/credit_fifo.sv
source/readout_port.sv
source/img_readout.sv
testbench/tb_clock.sv
testbench/img_readout_sva.sv
testbench/img_readout_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= img_readout_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
